//--- source/opcode_pkg.sv
// opcode block encodings and system state bits

package opcode_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame opcodes, bits 7:1 of the second header byte
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_NULL  = 7'd0,   // terminates the block
        OPC_FREQ  = 7'd2,   // frequency word, 4 bytes
        OPC_POWER = 7'd3,   // power word, 4 bytes
        OPC_PULSE = 7'd5,   // pulse word, 8 bytes
        OPC_BIAS  = 7'd6,   // bias word, 2 bytes
        OPC_ECHO  = 7'd12   // byte block, complemented back to host
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // block end status
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [7:0] {
        ST_SUCCESS             = 8'd0,
        ST_ERR_INVALID_OPCODE  = 8'd1,
        ST_ERR_PATTERN_RUNNING = 8'd2,   // byte block refused while pattern runs
        ST_ERR_RSP_FIFO_FULL   = 8'd3    // echo hit a full response fifo
    } status_e;

    // overall system state, pattern busy etc
    typedef logic [15:0] sys_state_t;

    localparam int SYS_PTN_BUSY_BIT = 0;   // pattern engine running

endpackage

//--- source/sink_pkg.sv
// word types for the opcode fifo and the sink fifos

package sink_pkg;

    typedef logic [7:0]  opc_byte_t;     // one opcode fifo byte
    typedef logic [8:0]  frame_len_t;    // payload length, msb from header byte 2
    typedef logic [63:0] arg_word_t;     // gathered integer argument, lsb first

    // sink fifo widths
    typedef logic [31:0] freq_word_t;    // frequency
    typedef logic [31:0] power_word_t;   // power
    typedef logic [63:0] pulse_word_t;   // pulse
    typedef logic [15:0] bias_word_t;    // bias

    typedef logic [31:0] counter_t;      // opcode counter at default width

endpackage

//--- source/opcode_cmd_if.sv
`timescale 1ns/1ps

// decoded frames from the parser to the sink writer
interface opcode_cmd_if import opcode_pkg::*, sink_pkg::*; ();

    logic      cmd_valid;    // integer frame complete
    opcode_e   cmd_opcode;
    arg_word_t cmd_arg;

    logic      echo_valid;   // one echo payload byte
    opc_byte_t echo_byte;
    logic      echo_last;    // echo frame done, response ready follows

    logic      end_valid;    // block finished
    status_e   end_status;

    logic      abort;        // writer saw a full response fifo

    modport parser (
        output cmd_valid, cmd_opcode, cmd_arg,
        output echo_valid, echo_byte, echo_last,
        output end_valid, end_status,
        input  abort
    );

    modport writer (
        input  cmd_valid, cmd_opcode, cmd_arg,
        input  echo_valid, echo_byte, echo_last,
        input  end_valid, end_status,
        output abort
    );

endinterface

//--- source/opcode_byte_fetch.sv
`timescale 1ns/1ps

// one read pulse per requested byte
// req -> rd_en -> valid, 2 cycles
module opcode_byte_fetch import sink_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_req_i,     // parser wants one byte
    input  opc_byte_t opc_data_i,     // fifo data, valid the cycle after rd_en
    output logic      opc_rd_en_o,
    output logic      byte_valid_o,
    output opc_byte_t byte_data_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            opc_rd_en_o  <= 1'b0;
            byte_valid_o <= 1'b0;
        end else begin
            opc_rd_en_o  <= byte_req_i;    // single pulse per request
            byte_valid_o <= opc_rd_en_o;   // fifo output settles one cycle later
        end
    end

    // fifo holds the read word on its output in the valid cycle
    assign byte_data_o = opc_data_i;

    // one byte outstanding, no request until the last one lands
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        byte_req_i |=> !byte_req_i [*2]
    );

endmodule

//--- source/opcode_frame_parser.sv
`timescale 1ns/1ps

// frame fsm that walks length lo, length hi with opcode and the payload
module opcode_frame_parser import opcode_pkg::*, sink_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       opc_empty_i,
    input  sys_state_t sys_state_i,
    output logic       byte_req_o,
    input  logic       byte_valid_i,
    input  opc_byte_t  byte_data_i,
    output logic       busy_o,
    opcode_cmd_if.parser cmd
);

    typedef enum logic [2:0] {
        IDLE,
        LEN_LO,
        LEN_HI,
        PAYLOAD,
        DISPATCH     // frame strobes out for one cycle
    } parse_state_e;

    parse_state_e state_q, state_d;

    opc_byte_t  len_lo_q;   // first header byte
    frame_len_t len_q;      // payload bytes
    frame_len_t idx_q;      // payload bytes taken so far
    opcode_e    opc_q;
    arg_word_t  arg_q;
    logic       pend_q;     // read in flight
    logic       busy_q;

    //////////////////////////////////////////////////////////////////////
    // header decode and frame end
    //////////////////////////////////////////////////////////////////////
    opcode_e    hdr_opc;
    frame_len_t hdr_len;
    logic       hdr_end;       // null or echo under pattern busy
    opcode_e    frame_opc;
    logic       frame_is_int;
    logic       frame_known;
    logic       fin;           // last byte of a frame at this edge
    logic       free_d;        // no read outstanding after this edge
    logic       req_d;

    assign hdr_opc = opcode_e'(byte_data_i[7:1]);
    assign hdr_len = {byte_data_i[0], len_lo_q};
    assign hdr_end = (hdr_opc == OPC_NULL) ||
                     (hdr_opc == OPC_ECHO && sys_state_i[SYS_PTN_BUSY_BIT]);

    // zero length frames end on the header byte
    assign frame_opc    = (state_q == LEN_HI) ? hdr_opc : opc_q;
    assign frame_is_int = frame_opc inside {OPC_FREQ, OPC_POWER, OPC_PULSE, OPC_BIAS};
    assign frame_known  = frame_is_int || (frame_opc == OPC_ECHO);

    assign fin = byte_valid_i &&
                 ((state_q == LEN_HI && !hdr_end && hdr_len == '0) ||
                  (state_q == PAYLOAD && idx_q == len_q - 1'b1));

    assign free_d = !byte_req_o && (!pend_q || byte_valid_i);
    assign req_d  = free_d && !opc_empty_i && (state_d inside {LEN_LO, LEN_HI, PAYLOAD});

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (!opc_empty_i && free_d) state_d = LEN_LO;   // stale byte drains first
            LEN_LO:   if (byte_valid_i) state_d = LEN_HI;
            LEN_HI:   if (byte_valid_i) state_d = hdr_end ? IDLE : PAYLOAD;
            DISPATCH: state_d = LEN_LO;
            default:  state_d = state_q;
        endcase
        if (fin)
            state_d = frame_known ? DISPATCH : IDLE;   // unknown ends after its payload
        if (cmd.abort)
            state_d = IDLE;
    end

    //////////////////////////////////////////////////////////////////////
    // control and strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        cmd.cmd_valid  <= 1'b0;   // all strobes single cycle
        cmd.echo_valid <= 1'b0;
        cmd.echo_last  <= 1'b0;
        cmd.end_valid  <= 1'b0;
        if (rst) begin
            state_q    <= IDLE;
            byte_req_o <= 1'b0;
            pend_q     <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            byte_req_o <= req_d;
            pend_q     <= (pend_q || byte_req_o) && !byte_valid_i;

            // busy spans the whole block
            if (byte_req_o)
                busy_q <= 1'b1;
            if (cmd.end_valid || cmd.abort)
                busy_q <= 1'b0;

            if (state_q == LEN_HI && byte_valid_i && hdr_end) begin
                cmd.end_valid <= 1'b1;
                if (hdr_opc == OPC_NULL)
                    cmd.end_status <= ST_SUCCESS;
                else
                    cmd.end_status <= ST_ERR_PATTERN_RUNNING;
            end
            if (fin && frame_is_int)
                cmd.cmd_valid <= 1'b1;
            if (fin && !frame_known) begin
                cmd.end_valid  <= 1'b1;
                cmd.end_status <= ST_ERR_INVALID_OPCODE;
            end
            if (state_q == PAYLOAD && byte_valid_i && opc_q == OPC_ECHO)
                cmd.echo_valid <= 1'b1;
            if (state_q == DISPATCH && opc_q == OPC_ECHO)
                cmd.echo_last <= 1'b1;   // trails the last response write
        end
    end

    // header and payload capture
    always_ff @(posedge clk) begin
        if (byte_valid_i) begin
            case (state_q)
                LEN_LO: len_lo_q <= byte_data_i;
                LEN_HI: begin
                    len_q <= hdr_len;
                    opc_q <= hdr_opc;
                    idx_q <= '0;
                    arg_q <= '0;
                end
                PAYLOAD: begin
                    idx_q         <= idx_q + 1'b1;
                    cmd.echo_byte <= byte_data_i;
                    if (idx_q[8:3] == '0)   // beyond 8 bytes read and dropped
                        arg_q[{idx_q[2:0], 3'b000} +: 8] <= byte_data_i;
                end
                default: ;
            endcase
        end
    end

    assign cmd.cmd_opcode = opc_q;
    assign cmd.cmd_arg    = arg_q;
    assign busy_o         = busy_q;

    a_cmd_end_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(cmd.cmd_valid && cmd.end_valid)
    );

endmodule

//--- source/opcode_sink_writer.sv
`timescale 1ns/1ps

// sink words, write strobes, echo response, counter and status
module opcode_sink_writer import opcode_pkg::*, sink_pkg::*; #(
    parameter int COUNTER_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    opcode_cmd_if.writer         cmd,
    input  logic                 response_full_i,
    output freq_word_t           frequency_o,
    output logic                 frq_wr_en_o,
    output power_word_t          power_o,
    output logic                 pwr_wr_en_o,
    output pulse_word_t          pulse_o,
    output logic                 pulse_wr_en_o,
    output bias_word_t           bias_o,
    output logic                 bias_wr_en_o,
    output opc_byte_t            response_o,
    output logic                 response_wr_en_o,
    output logic                 response_ready_o,
    output logic [COUNTER_W-1:0] opcode_counter_o,
    output status_e              status_o
);

    logic echo_ok;    // echo byte fits in the response fifo
    logic echo_full;  // echo byte meets a full fifo

    assign echo_ok   = cmd.echo_valid && !response_full_i;
    assign echo_full = cmd.echo_valid && response_full_i;

    //////////////////////////////////////////////////////////////////////
    // strobes, counter, status
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            frq_wr_en_o      <= 1'b0;
            pwr_wr_en_o      <= 1'b0;
            pulse_wr_en_o    <= 1'b0;
            bias_wr_en_o     <= 1'b0;
            response_wr_en_o <= 1'b0;
            response_ready_o <= 1'b0;
            cmd.abort        <= 1'b0;
            opcode_counter_o <= '0;
            status_o         <= ST_SUCCESS;
        end else begin
            frq_wr_en_o   <= cmd.cmd_valid && (cmd.cmd_opcode == OPC_FREQ);
            pwr_wr_en_o   <= cmd.cmd_valid && (cmd.cmd_opcode == OPC_POWER);
            pulse_wr_en_o <= cmd.cmd_valid && (cmd.cmd_opcode == OPC_PULSE);
            bias_wr_en_o  <= cmd.cmd_valid && (cmd.cmd_opcode == OPC_BIAS);

            if (cmd.cmd_valid)
                opcode_counter_o <= opcode_counter_o + 1'b1;   // one per sink word

            response_wr_en_o <= echo_ok;
            cmd.abort        <= echo_full;
            // no ready pulse once the echo was cut short
            response_ready_o <= cmd.echo_last && !cmd.abort;

            if (echo_full)
                status_o <= ST_ERR_RSP_FIFO_FULL;
            else if (cmd.end_valid)
                status_o <= cmd.end_status;
        end
    end

    // payload registers, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (cmd.cmd_valid) begin
            case (cmd.cmd_opcode)
                OPC_FREQ:  frequency_o <= freq_word_t'(cmd.cmd_arg);   // low bytes only
                OPC_POWER: power_o     <= power_word_t'(cmd.cmd_arg);
                OPC_PULSE: pulse_o     <= pulse_word_t'(cmd.cmd_arg);
                OPC_BIAS:  bias_o      <= bias_word_t'(cmd.cmd_arg);
                default: ;
            endcase
        end
        if (echo_ok)
            response_o <= ~cmd.echo_byte;   // complement for the echo test
    end

    // parser sends one frame at a time, so writes never overlap
    a_one_write: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({frq_wr_en_o, pwr_wr_en_o, pulse_wr_en_o, bias_wr_en_o, response_wr_en_o})
    );

endmodule

//--- source/opcode_engine.sv
`timescale 1ns/1ps

// opcode engine top: byte fetch, frame parser, sink writer
module opcode_engine import opcode_pkg::*, sink_pkg::*; #(
    parameter int COUNTER_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,

    // opcode fifo
    input  opc_byte_t            opc_data_i,
    input  logic                 opc_empty_i,
    output logic                 opc_rd_en_o,

    input  sys_state_t           sys_state_i,

    // sink fifos
    output freq_word_t           frequency_o,
    output logic                 frq_wr_en_o,
    output power_word_t          power_o,
    output logic                 pwr_wr_en_o,
    output pulse_word_t          pulse_o,
    output logic                 pulse_wr_en_o,
    output bias_word_t           bias_o,
    output logic                 bias_wr_en_o,

    // response fifo
    output opc_byte_t            response_o,
    output logic                 response_wr_en_o,
    input  logic                 response_full_i,
    output logic                 response_ready_o,

    // block result
    output logic [COUNTER_W-1:0] opcode_counter_o,
    output status_e              status_o,
    output logic                 busy_o
);

    logic      byte_req;
    logic      byte_valid;
    opc_byte_t byte_data;

    opcode_cmd_if i_cmd ();

    //////////////////////////////////////////////////////////////////////
    // fetch -> parser -> writer
    //////////////////////////////////////////////////////////////////////
    opcode_byte_fetch i_fetch (
        .clk          (clk),
        .rst          (rst),
        .byte_req_i   (byte_req),
        .opc_data_i   (opc_data_i),
        .opc_rd_en_o  (opc_rd_en_o),
        .byte_valid_o (byte_valid),
        .byte_data_o  (byte_data)
    );

    opcode_frame_parser i_parser (
        .clk          (clk),
        .rst          (rst),
        .opc_empty_i  (opc_empty_i),
        .sys_state_i  (sys_state_i),
        .byte_req_o   (byte_req),
        .byte_valid_i (byte_valid),
        .byte_data_i  (byte_data),
        .busy_o       (busy_o),      // block busy straight out
        .cmd          (i_cmd.parser)
    );

    opcode_sink_writer #(
        .COUNTER_W (COUNTER_W)
    ) i_writer (
        .clk              (clk),
        .rst              (rst),
        .cmd              (i_cmd.writer),
        .response_full_i  (response_full_i),
        .frequency_o      (frequency_o),
        .frq_wr_en_o      (frq_wr_en_o),
        .power_o          (power_o),
        .pwr_wr_en_o      (pwr_wr_en_o),
        .pulse_o          (pulse_o),
        .pulse_wr_en_o    (pulse_wr_en_o),
        .bias_o           (bias_o),
        .bias_wr_en_o     (bias_wr_en_o),
        .response_o       (response_o),
        .response_wr_en_o (response_wr_en_o),
        .response_ready_o (response_ready_o),
        .opcode_counter_o (opcode_counter_o),
        .status_o         (status_o)
    );

endmodule

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// error reporting
//////////////////////////////////////////////////////////////////////
task automatic report_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
    errors++;
endtask

task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
endtask

task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else report_mismatch(what, exp, act);
endtask

//////////////////////////////////////////////////////////////////////
// strobe checks against the expected words of the running test
//////////////////////////////////////////////////////////////////////
a_frq_value: assert property (@(posedge clk) disable iff (rst)
    frq_wr_en_o |-> frequency_o == exp_freq)
    else report_mismatch("frequency", exp_freq, $sampled(frequency_o));

a_pwr_value: assert property (@(posedge clk) disable iff (rst)
    pwr_wr_en_o |-> power_o == exp_power)
    else report_mismatch("power", exp_power, $sampled(power_o));

a_pulse_value: assert property (@(posedge clk) disable iff (rst)
    pulse_wr_en_o |-> pulse_o == exp_pulse)
    else report_mismatch("pulse", exp_pulse, $sampled(pulse_o));

a_bias_value: assert property (@(posedge clk) disable iff (rst)
    bias_wr_en_o |-> bias_o == exp_bias)
    else report_mismatch("bias", exp_bias, $sampled(bias_o));

// mask bits {bias, pulse, power, freq}
a_sink_allowed: assert property (@(posedge clk) disable iff (rst)
    ({bias_wr_en_o, pulse_wr_en_o, pwr_wr_en_o, frq_wr_en_o} & ~sink_allow) == 4'b0000)
    else report_failure("a sink write strobe fired that this test does not expect");

// nth response write carries the complement of the nth echo byte
a_rsp_value: assert property (@(posedge clk) disable iff (rst)
    response_wr_en_o && rsp_allow |-> response_o == ~echo_exp[4'(rsp_cnt - rsp_base)])
    else report_mismatch("response byte", opc_byte_t'(~echo_exp[4'(rsp_cnt - rsp_base)]),
                         $sampled(response_o));

a_rsp_allowed: assert property (@(posedge clk) disable iff (rst)
    response_wr_en_o |-> rsp_allow)
    else report_failure("a response write happened that this test does not expect");

a_ready_after_writes: assert property (@(posedge clk) disable iff (rst)
    response_ready_o |-> (rsp_cnt - rsp_base) == echo_len)
    else report_failure("response ready pulsed before all echo bytes were written");

//////////////////////////////////////////////////////////////////////
// end of block
//////////////////////////////////////////////////////////////////////
task automatic check_block_end(input status_e exp_st, input int cnt_delta);
    check_value("status", exp_st, status_o);
    check_value("opcode counter", cnt_delta, opcode_counter_o - cnt_base);
    assert (!busy_o) else report_failure("busy still high after the block");
endtask

task automatic check_reset_state();
    check_value("sink strobes", 4'b0000,
                {bias_wr_en_o, pulse_wr_en_o, pwr_wr_en_o, frq_wr_en_o});
    check_value("response strobes", 2'b00, {response_wr_en_o, response_ready_o});
    check_value("rd_en and busy", 2'b00, {opc_rd_en_o, busy_o});
    check_value("opcode counter", 0, opcode_counter_o);
    check_value("status", ST_SUCCESS, status_o);
endtask

`endif

//--- tests/tb_opcode_engine.sv
`timescale 1ns/1ps

module tb_opcode_engine import opcode_pkg::*, sink_pkg::*; ();

    localparam int QUEUED_BYTES    = 309;   // all frames of all tests
    localparam int WATCHDOG_CYCLES = QUEUED_BYTES * 40 + 200;

    logic        clk = 1'b0;
    logic        rst;
    opc_byte_t   opc_data_i;
    logic        opc_empty_i;
    logic        opc_rd_en_o;
    sys_state_t  sys_state_i;
    freq_word_t  frequency_o;
    power_word_t power_o;
    pulse_word_t pulse_o;
    bias_word_t  bias_o;
    logic        frq_wr_en_o, pwr_wr_en_o, pulse_wr_en_o, bias_wr_en_o;
    opc_byte_t   response_o;
    logic        response_wr_en_o, response_full_i, response_ready_o;
    counter_t    opcode_counter_o;
    status_e     status_o;
    logic        busy_o;

    opc_byte_t   byte_q [$];       // opcode fifo contents
    string       test_name;
    int          errors = 0, err_base, tests_run = 0, tests_failed = 0;
    freq_word_t  exp_freq;
    power_word_t exp_power;
    pulse_word_t exp_pulse;
    bias_word_t  exp_bias;
    logic [3:0]  sink_allow;       // {bias, pulse, power, freq}
    logic        rsp_allow;
    opc_byte_t   echo_exp [16];
    int          echo_len;
    int          sink_cnt [4] = '{default: 0}, sink_base [4];
    int          rsp_cnt = 0, rsp_base, ready_cnt = 0, ready_base, cnt_base;
    arg_word_t   w;

    always #4 clk = ~clk;

    opcode_engine #(.COUNTER_W(32)) i_dut (
        .clk(clk), .rst(rst),
        .opc_data_i(opc_data_i), .opc_empty_i(opc_empty_i), .opc_rd_en_o(opc_rd_en_o),
        .sys_state_i(sys_state_i),
        .frequency_o(frequency_o), .frq_wr_en_o(frq_wr_en_o),
        .power_o(power_o), .pwr_wr_en_o(pwr_wr_en_o),
        .pulse_o(pulse_o), .pulse_wr_en_o(pulse_wr_en_o),
        .bias_o(bias_o), .bias_wr_en_o(bias_wr_en_o),
        .response_o(response_o), .response_wr_en_o(response_wr_en_o),
        .response_full_i(response_full_i), .response_ready_o(response_ready_o),
        .opcode_counter_o(opcode_counter_o), .status_o(status_o), .busy_o(busy_o)
    );

    `include "tb_checks.svh"

    // fifo model returns data one cycle after rd_en
    always @(posedge clk) begin
        if (opc_rd_en_o) begin
            if (byte_q.size() > 0)
                opc_data_i <= byte_q.pop_front();
            else
                report_failure("opcode FIFO read while it was empty");
        end
        opc_empty_i <= (byte_q.size() == 0);
    end

    // strobe counters
    always @(posedge clk) begin
        if (frq_wr_en_o)      sink_cnt[0] <= sink_cnt[0] + 1;
        if (pwr_wr_en_o)      sink_cnt[1] <= sink_cnt[1] + 1;
        if (pulse_wr_en_o)    sink_cnt[2] <= sink_cnt[2] + 1;
        if (bias_wr_en_o)     sink_cnt[3] <= sink_cnt[3] + 1;
        if (response_wr_en_o) rsp_cnt     <= rsp_cnt + 1;
        if (response_ready_o) ready_cnt   <= ready_cnt + 1;
    end

    task automatic push_header(input frame_len_t len, input logic [6:0] opc);
        byte_q.push_back(len[7:0]);
        byte_q.push_back({opc, len[8]});   // opcode in 7:1 and length msb in bit 0
    endtask

    // random payload with the word gathered lsb first
    task automatic push_int_frame(input logic [6:0] opc, input int n, output arg_word_t word);
        opc_byte_t b;
        word = '0;
        push_header(frame_len_t'(n), opc);
        for (int i = 0; i < n; i++) begin
            b = opc_byte_t'($urandom);
            byte_q.push_back(b);
            if (i < 8)
                word[i*8 +: 8] = b;
        end
    endtask

    task automatic begin_test(input string name, input logic [3:0] sinks, input logic rsp);
        @(negedge clk);
        test_name  = name;
        err_base   = errors;
        sink_allow = sinks;
        rsp_allow  = rsp;
        echo_len   = 0;
        sink_base  = sink_cnt;
        rsp_base   = rsp_cnt;
        ready_base = ready_cnt;
        cnt_base   = opcode_counter_o;
    endtask

    // busy spans the block and its fall marks the end
    task automatic run_block();
        while (!busy_o) @(negedge clk);
        while (busy_o) @(negedge clk);
        repeat (3) @(negedge clk);   // trailing strobes
    endtask

    task automatic check_counts(input int frq, input int pwr, input int pls, input int bias,
                                input int rsp, input int rdy);
        check_value("freq writes", frq, sink_cnt[0] - sink_base[0]);
        check_value("power writes", pwr, sink_cnt[1] - sink_base[1]);
        check_value("pulse writes", pls, sink_cnt[2] - sink_base[2]);
        check_value("bias writes", bias, sink_cnt[3] - sink_base[3]);
        check_value("response writes", rsp, rsp_cnt - rsp_base);
        check_value("ready pulses", rdy, ready_cnt - ready_base);
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > err_base) begin
            tests_failed++;
            $display("%-26s failing, %0d errors", test_name, errors - err_base);
        end else begin
            $display("%-26s ok", test_name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h245c51f0));
        rst = 1'b1;
        opc_data_i = '0;
        opc_empty_i = 1'b1;
        sys_state_i = '0;
        response_full_i = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset and long length", 4'b1000, 1'b0);
        check_reset_state();
        push_int_frame(OPC_BIAS, 258, w);   // only the first two bytes land
        exp_bias = w[15:0];
        push_header(0, OPC_NULL);
        run_block();
        check_block_end(ST_SUCCESS, 1);
        check_counts(0, 0, 0, 1, 0, 0);
        end_test();

        begin_test("integer opcodes", 4'b1111, 1'b0);
        push_int_frame(OPC_FREQ, 4, w);
        exp_freq = w[31:0];
        push_int_frame(OPC_POWER, 4, w);
        exp_power = w[31:0];
        push_int_frame(OPC_PULSE, 8, w);
        exp_pulse = w;
        push_int_frame(OPC_BIAS, 2, w);
        exp_bias = w[15:0];
        push_header(0, OPC_NULL);
        run_block();
        check_block_end(ST_SUCCESS, 4);
        check_counts(1, 1, 1, 1, 0, 0);
        end_test();

        begin_test("echo", 4'b0000, 1'b1);
        echo_len = 6;
        push_header(6, OPC_ECHO);
        for (int i = 0; i < 6; i++) begin
            echo_exp[i] = opc_byte_t'($urandom);
            byte_q.push_back(echo_exp[i]);
        end
        push_header(0, OPC_NULL);
        run_block();
        check_block_end(ST_SUCCESS, 0);
        check_counts(0, 0, 0, 0, 6, 1);
        end_test();

        begin_test("unknown opcode", 4'b0000, 1'b0);
        push_int_frame(7'd9, 2, w);
        run_block();
        check_block_end(ST_ERR_INVALID_OPCODE, 0);
        check_counts(0, 0, 0, 0, 0, 0);
        end_test();

        begin_test("pattern running", 4'b0000, 1'b0);
        @(posedge clk) sys_state_i <= 16'h0001;   // pattern busy bit
        @(negedge clk) push_header(0, OPC_ECHO);
        run_block();
        check_block_end(ST_ERR_PATTERN_RUNNING, 0);
        check_counts(0, 0, 0, 0, 0, 0);
        @(posedge clk) sys_state_i <= '0;
        end_test();

        begin_test("response fifo full", 4'b0000, 1'b0);
        @(posedge clk) response_full_i <= 1'b1;
        @(negedge clk) push_int_frame(OPC_ECHO, 1, w);
        run_block();
        check_block_end(ST_ERR_RSP_FIFO_FULL, 0);
        check_counts(0, 0, 0, 0, 0, 0);
        @(posedge clk) response_full_i <= 1'b0;
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog scaled to the queued bytes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a block never finished", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+tests
source/opcode_pkg.sv
source/sink_pkg.sv
source/opcode_cmd_if.sv
source/opcode_byte_fetch.sv
source/opcode_frame_parser.sv
source/opcode_sink_writer.sv
source/opcode_engine.sv
tests/tb_opcode_engine.sv
